/* hdl/simd_settings.svh */
// shared widths and opcodes; the vector length must stay a multiple of 8 to fit the adder tree
`ifndef SIMD_SETTINGS_SVH
`define SIMD_SETTINGS_SVH

// element and result width
`define SIMD_DATA_WIDTH     16
`define SIMD_VECTOR_LENGTH  16

// 256 words per memory
`define SIMD_ADDR_WIDTH     8

// instruction layout is {opcode, src, dst}
`define SIMD_OPCODE_WIDTH   3
`define SIMD_INST_WIDTH     19

`define SIMD_OP_DOT         3'd1
`define SIMD_OP_LOAD_INPUT  3'd3
`define SIMD_OP_LOAD_WEIGHT 3'd4
`define SIMD_OP_READ        3'd5

`endif

/* hdl/simd_pkg.sv */
// types only, all unsigned; vec_t packs element k at bits 16k upward
`include "simd_settings.svh"

package simd_pkg;

    // one element or one dot-product result
    typedef logic [`SIMD_DATA_WIDTH-1:0] data_t;

    typedef logic [`SIMD_ADDR_WIDTH-1:0] addr_t;

    // flat vector, element 0 in the low bits
    typedef logic [`SIMD_VECTOR_LENGTH*`SIMD_DATA_WIDTH-1:0] vec_t;

    typedef logic [`SIMD_INST_WIDTH-1:0] inst_t;

    typedef logic [`SIMD_OPCODE_WIDTH-1:0] opcode_t;

    // {ADD2, ADD1, ADD0, MUL}
    typedef logic [3:0] pipe_status_t;

endpackage

/* hdl/simd_sram.sv */
// one write and one registered read port, no reset, contents undefined until written
`timescale 1ns/100ps

module simd_sram #(
    parameter int WIDTH = 16
) (
    input  logic                clk,

    input  logic                i_wen,
    input  simd_pkg::addr_t     i_waddr,
    input  logic [WIDTH-1:0]    i_wdata,

    input  logic                i_ren,
    input  simd_pkg::addr_t     i_raddr,
    output logic [WIDTH-1:0]    o_rdata
);

    localparam int DEPTH = 1 << $bits(simd_pkg::addr_t);

    logic [WIDTH-1:0] mem [0:DEPTH-1];
    logic [WIDTH-1:0] rdata_ff;

    always_ff @(posedge clk) begin
        if (i_wen) begin
            mem[i_waddr] <= i_wdata;
        end
    end

    // read data holds while the port is idle
    always_ff @(posedge clk) begin
        if (i_ren) begin
            rdata_ff <= mem[i_raddr];
        end
    end

    assign o_rdata = rdata_ff;

endmodule

/* hdl/inst_decoder.sv */
// i_valid is a single-cycle strobe with no back-pressure; opcodes 0, 2, 6 and 7 are ignored
`timescale 1ns/100ps
`include "simd_settings.svh"

module inst_decoder (
    input  logic                clk,
    input  logic                reset_ff,

    input  logic                i_valid,
    input  simd_pkg::inst_t     i_instruction,

    // input memory
    output logic                o_imem_wen,
    output simd_pkg::addr_t     o_imem_waddr,
    output logic                o_imem_ren,
    output simd_pkg::addr_t     o_imem_raddr,

    // output memory read side
    output logic                o_omem_ren,
    output simd_pkg::addr_t     o_omem_raddr,

    // dot pipeline
    output logic                o_weight_load,
    output logic                o_dot_valid,
    output simd_pkg::addr_t     o_dot_dst,

    output logic                o_done
);

    localparam int AW = `SIMD_ADDR_WIDTH;

    simd_pkg::opcode_t  opcode;
    simd_pkg::addr_t    src_addr;
    simd_pkg::addr_t    dst_addr;

    logic               is_dot;
    logic               is_load_input;
    logic               is_load_weight;
    logic               is_read;

    logic               dot_valid_ff;
    simd_pkg::addr_t    dot_dst_ff;
    logic               done_ff;

    // {opcode, src, dst}
    assign opcode   = i_instruction[`SIMD_INST_WIDTH-1 -: `SIMD_OPCODE_WIDTH];
    assign src_addr = i_instruction[2*AW-1 -: AW];
    assign dst_addr = i_instruction[AW-1:0];

    assign is_dot         = i_valid && (opcode == `SIMD_OP_DOT);
    assign is_load_input  = i_valid && (opcode == `SIMD_OP_LOAD_INPUT);
    assign is_load_weight = i_valid && (opcode == `SIMD_OP_LOAD_WEIGHT);
    assign is_read        = i_valid && (opcode == `SIMD_OP_READ);

    // cycle 0 strobes
    assign o_imem_wen    = is_load_input;
    assign o_imem_waddr  = dst_addr;
    assign o_imem_ren    = is_dot;
    assign o_imem_raddr  = src_addr;
    assign o_omem_ren    = is_read;
    assign o_omem_raddr  = src_addr;
    assign o_weight_load = is_load_weight;

    always_ff @(posedge clk) begin
        if (reset_ff) begin
            dot_valid_ff <= 1'b0;
            done_ff      <= 1'b0;
        end else begin
            dot_valid_ff <= is_dot;
            // ack for loads and reads, one cycle after issue
            done_ff      <= is_load_input | is_load_weight | is_read;
        end
    end

    // dst travels with the input memory read data
    always_ff @(posedge clk) begin
        if (is_dot) begin
            dot_dst_ff <= dst_addr;
        end
    end

    assign o_dot_valid = dot_valid_ff;
    assign o_dot_dst   = dot_dst_ff;
    assign o_done      = done_ff;

endmodule

/* hdl/dot_pipe.sv */
// fixed 5-cycle latency from issue to write-back; products and sums wrap modulo 2^16
`timescale 1ns/100ps
`include "simd_settings.svh"

module dot_pipe (
    input  logic                    clk,
    input  logic                    reset_ff,

    input  logic                    i_weight_load,
    input  simd_pkg::vec_t          i_weight,

    input  logic                    i_dot_valid,
    input  simd_pkg::addr_t         i_dot_dst,
    input  simd_pkg::vec_t          i_vector,

    output logic                    o_wr_en,
    output simd_pkg::addr_t         o_wr_addr,
    output simd_pkg::data_t         o_result,
    output simd_pkg::pipe_status_t  o_pipe_status
);

    localparam int DW     = `SIMD_DATA_WIDTH;
    localparam int LANES  = `SIMD_VECTOR_LENGTH;
    localparam int ADD0_N = LANES / 4;
    localparam int ADD1_N = ADD0_N / 2;

    simd_pkg::vec_t     weight_ff;

    simd_pkg::data_t    product  [LANES];
    simd_pkg::data_t    add0_nxt [ADD0_N];
    simd_pkg::data_t    add1_nxt [ADD1_N];
    simd_pkg::data_t    add2_nxt;

    simd_pkg::data_t    mul_ff   [LANES];
    simd_pkg::data_t    add0_ff  [ADD0_N];
    simd_pkg::data_t    add1_ff  [ADD1_N];
    simd_pkg::data_t    add2_ff;

    logic               mul_valid_ff;
    logic               add0_valid_ff;
    logic               add1_valid_ff;
    logic               add2_valid_ff;

    simd_pkg::addr_t    mul_dst_ff;
    simd_pkg::addr_t    add0_dst_ff;
    simd_pkg::addr_t    add1_dst_ff;
    simd_pkg::addr_t    add2_dst_ff;

    // low 16 bits of each product are enough for the wrapped sum
    always_comb begin
        for (int k = 0; k < LANES; k++) begin
            product[k] = i_vector[k*DW +: DW] * weight_ff[k*DW +: DW];
        end
    end

    // 16 to 4
    always_comb begin
        for (int j = 0; j < ADD0_N; j++) begin
            add0_nxt[j] = '0;
            for (int k = 0; k < 4; k++) begin
                add0_nxt[j] += mul_ff[4*j+k];
            end
        end
    end

    // 4 to 2, then 2 to 1
    always_comb begin
        for (int j = 0; j < ADD1_N; j++) begin
            add1_nxt[j] = add0_ff[2*j] + add0_ff[2*j+1];
        end
        add2_nxt = '0;
        for (int j = 0; j < ADD1_N; j++) begin
            add2_nxt += add1_ff[j];
        end
    end

    always_ff @(posedge clk) begin
        if (reset_ff) begin
            weight_ff     <= '0;
            mul_valid_ff  <= 1'b0;
            add0_valid_ff <= 1'b0;
            add1_valid_ff <= 1'b0;
            add2_valid_ff <= 1'b0;
        end else begin
            if (i_weight_load) begin
                weight_ff <= i_weight;
            end
            mul_valid_ff  <= i_dot_valid;
            add0_valid_ff <= mul_valid_ff;
            add1_valid_ff <= add0_valid_ff;
            add2_valid_ff <= add1_valid_ff;
        end
    end

    // payload only moves with a valid entry
    always_ff @(posedge clk) begin
        if (i_dot_valid) begin
            mul_ff     <= product;
            mul_dst_ff <= i_dot_dst;
        end
        if (mul_valid_ff) begin
            add0_ff     <= add0_nxt;
            add0_dst_ff <= mul_dst_ff;
        end
        if (add0_valid_ff) begin
            add1_ff     <= add1_nxt;
            add1_dst_ff <= add0_dst_ff;
        end
        if (add1_valid_ff) begin
            add2_ff     <= add2_nxt;
            add2_dst_ff <= add1_dst_ff;
        end
    end

    assign o_wr_en       = add2_valid_ff;
    assign o_wr_addr     = add2_dst_ff;
    assign o_result      = add2_ff;
    assign o_pipe_status = {add2_valid_ff, add1_valid_ff, add0_valid_ff, mul_valid_ff};

endmodule

/* hdl/simd_top.sv */
// one instruction per i_valid cycle with no stall; o_data is only meaningful in the o_done cycle of a read
`timescale 1ns/100ps

module simd_top (
    input  logic                    clk,
    input  logic                    reset_ff,

    input  logic                    i_valid,
    input  simd_pkg::inst_t         i_instruction,
    input  simd_pkg::vec_t          i_data,

    output simd_pkg::data_t         o_data,
    output logic                    o_done,
    output logic                    o_dot_done,
    output simd_pkg::pipe_status_t  o_pipe_status
);

    logic               imem_wen;
    simd_pkg::addr_t    imem_waddr;
    logic               imem_ren;
    simd_pkg::addr_t    imem_raddr;
    simd_pkg::vec_t     imem_rdata;

    logic               omem_ren;
    simd_pkg::addr_t    omem_raddr;
    logic               omem_wen;
    simd_pkg::addr_t    omem_waddr;
    simd_pkg::data_t    omem_wdata;

    logic               weight_load;
    logic               dot_valid;
    simd_pkg::addr_t    dot_dst;

    inst_decoder inst_decoder_i (
        .clk            (clk),
        .reset_ff       (reset_ff),
        .i_valid        (i_valid),
        .i_instruction  (i_instruction),
        .o_imem_wen     (imem_wen),
        .o_imem_waddr   (imem_waddr),
        .o_imem_ren     (imem_ren),
        .o_imem_raddr   (imem_raddr),
        .o_omem_ren     (omem_ren),
        .o_omem_raddr   (omem_raddr),
        .o_weight_load  (weight_load),
        .o_dot_valid    (dot_valid),
        .o_dot_dst      (dot_dst),
        .o_done         (o_done)
    );

    // input vectors
    simd_sram #(
        .WIDTH  ($bits(simd_pkg::vec_t))
    ) imem_i (
        .clk        (clk),
        .i_wen      (imem_wen),
        .i_waddr    (imem_waddr),
        .i_wdata    (i_data),
        .i_ren      (imem_ren),
        .i_raddr    (imem_raddr),
        .o_rdata    (imem_rdata)
    );

    // scalar results
    simd_sram #(
        .WIDTH  ($bits(simd_pkg::data_t))
    ) omem_i (
        .clk        (clk),
        .i_wen      (omem_wen),
        .i_waddr    (omem_waddr),
        .i_wdata    (omem_wdata),
        .i_ren      (omem_ren),
        .i_raddr    (omem_raddr),
        .o_rdata    (o_data)
    );

    dot_pipe dot_pipe_i (
        .clk            (clk),
        .reset_ff       (reset_ff),
        .i_weight_load  (weight_load),
        .i_weight       (i_data),
        .i_dot_valid    (dot_valid),
        .i_dot_dst      (dot_dst),
        .i_vector       (imem_rdata),
        .o_wr_en        (omem_wen),
        .o_wr_addr      (omem_waddr),
        .o_result       (omem_wdata),
        .o_pipe_status  (o_pipe_status)
    );

    assign o_dot_done = omem_wen;

endmodule

/* verif/tb_clock.sv */
// free-running testbench clock starting low, period given in ns
`timescale 1ns/100ps

module tb_clock #(
    parameter int PERIOD_NS = 4
) (
    output logic o_clk
);

    initial begin
        o_clk = 1'b0;
    end

    always begin
        #(PERIOD_NS / 2.0);
        o_clk = ~o_clk;
    end

endmodule

/* verif/simd_tb.sv */
// self-checking testbench; reads only addresses it has written, since memories start undefined
`timescale 1ns/100ps
`include "simd_settings.svh"

module simd_tb;

    localparam int CLK_PERIOD  = 4;
    localparam int NUM_LOADS   = 24;
    localparam int NUM_BURST   = 8;
    localparam int NUM_IGNORED = 16;
    // fixed-length parts of the sequence fit well inside the extra 64 slots
    localparam int NUM_INSTR   = NUM_LOADS + 2 * NUM_BURST + NUM_IGNORED + 64;
    localparam int DW          = `SIMD_DATA_WIDTH;
    localparam int AW          = `SIMD_ADDR_WIDTH;
    localparam int DEPTH       = 1 << AW;

    typedef struct packed {
        logic [31:0]     issue_cycle;
        simd_pkg::addr_t dst;
        simd_pkg::data_t result;
    } dot_entry_t;

    logic                   clk;
    logic                   reset_ff;
    logic                   i_valid;
    simd_pkg::inst_t        i_instruction;
    simd_pkg::vec_t         i_data;
    simd_pkg::data_t        o_data;
    logic                   o_done;
    logic                   o_dot_done;
    simd_pkg::pipe_status_t o_pipe_status;

    // reference model state
    simd_pkg::vec_t         imem_model [DEPTH];
    simd_pkg::data_t        omem_model [DEPTH];
    simd_pkg::vec_t         weight_model;
    dot_entry_t             inflight [$];
    simd_pkg::addr_t        loaded_src [$];
    simd_pkg::addr_t        result_dst [$];

    logic                   exp_done;
    logic                   exp_read;
    simd_pkg::data_t        exp_rdata;

    logic [31:0]            lfsr_state;
    int                     cycle_count;
    int                     checks;
    int                     errors;

    tb_clock #(
        .PERIOD_NS  (CLK_PERIOD)
    ) tb_clock_i (
        .o_clk  (clk)
    );

    simd_top simd_top_i (
        .clk            (clk),
        .reset_ff       (reset_ff),
        .i_valid        (i_valid),
        .i_instruction  (i_instruction),
        .i_data         (i_data),
        .o_data         (o_data),
        .o_done         (o_done),
        .o_dot_done     (o_dot_done),
        .o_pipe_status  (o_pipe_status)
    );

    // galois form with taps 32 30 26 25
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ 32'hA300_0000) : (state >> 1);
    endfunction

    function automatic logic [31:0] next_bits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            bits = {bits[30:0], lfsr_state[0]};
        end
        return bits;
    endfunction

    function automatic simd_pkg::addr_t random_addr();
        logic [31:0] bits;
        bits = next_bits(AW);
        return bits[AW-1:0];
    endfunction

    function automatic simd_pkg::vec_t random_vector();
        simd_pkg::vec_t v;
        for (int i = 0; i < $bits(simd_pkg::vec_t) / 32; i++) begin
            v[32*i +: 32] = next_bits(32);
        end
        return v;
    endfunction

    // sum of full 32-bit products with only its low 16 bits kept
    function automatic simd_pkg::data_t expected_dot(input simd_pkg::vec_t a,
                                                     input simd_pkg::vec_t w);
        logic [31:0] acc;
        acc = '0;
        for (int k = 0; k < `SIMD_VECTOR_LENGTH; k++) begin
            acc += a[k*DW +: DW] * w[k*DW +: DW];
        end
        return acc[DW-1:0];
    endfunction

    function automatic simd_pkg::inst_t make_inst(input simd_pkg::opcode_t op,
                                                  input simd_pkg::addr_t src,
                                                  input simd_pkg::addr_t dst);
        return {op, src, dst};
    endfunction

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // checks this cycle's outputs before driving and modeling a new instruction
    task automatic run_cycle(input logic valid, input simd_pkg::inst_t inst,
                             input simd_pkg::vec_t data);
        simd_pkg::opcode_t      op;
        simd_pkg::addr_t        src;
        simd_pkg::addr_t        dst;
        simd_pkg::pipe_status_t exp_status;
        logic                   exp_dot_done;
        dot_entry_t             ent;
        int                     age;
        @(posedge clk);
        #1;
        cycle_count++;
        exp_status   = '0;
        exp_dot_done = 1'b0;
        foreach (inflight[i]) begin
            age = cycle_count - int'(inflight[i].issue_cycle);
            if (age >= 2 && age <= 5) begin
                exp_status[age-2] = 1'b1;
            end
            if (age == 5) begin
                exp_dot_done = 1'b1;
            end
        end
        compare_value("o_done", o_done, exp_done);
        compare_value("o_dot_done", o_dot_done, exp_dot_done);
        compare_value("o_pipe_status", o_pipe_status, exp_status);
        if (exp_read) begin
            compare_value("o_data", o_data, exp_rdata);
        end
        exp_done = 1'b0;
        exp_read = 1'b0;

        i_valid       = valid;
        i_instruction = inst;
        i_data        = data;
        op  = inst[`SIMD_INST_WIDTH-1 -: `SIMD_OPCODE_WIDTH];
        src = inst[2*AW-1 -: AW];
        dst = inst[AW-1:0];
        if (valid) begin
            case (op)
                `SIMD_OP_LOAD_INPUT: begin
                    imem_model[dst] = data;
                    exp_done = 1'b1;
                end
                `SIMD_OP_LOAD_WEIGHT: begin
                    weight_model = data;
                    exp_done = 1'b1;
                end
                `SIMD_OP_READ: begin
                    exp_done  = 1'b1;
                    exp_read  = 1'b1;
                    exp_rdata = omem_model[src];
                end
                `SIMD_OP_DOT: begin
                    ent.issue_cycle = cycle_count;
                    ent.dst         = dst;
                    ent.result      = expected_dot(imem_model[src], weight_model);
                    inflight.push_back(ent);
                end
                default: begin
                end
            endcase
        end

        // results land at the edge ending cycle 5 after any read issued in it
        while (inflight.size() > 0 && int'(inflight[0].issue_cycle) + 5 == cycle_count) begin
            ent = inflight.pop_front();
            omem_model[ent.dst] = ent.result;
        end
    endtask

    task automatic issue_instr(input simd_pkg::opcode_t op, input simd_pkg::addr_t src,
                               input simd_pkg::addr_t dst, input simd_pkg::vec_t data);
        run_cycle(1'b1, make_inst(op, src, dst), data);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            run_cycle(1'b0, '0, '0);
        end
    endtask

    task automatic issue_dot(input simd_pkg::addr_t src, input simd_pkg::addr_t dst);
        issue_instr(`SIMD_OP_DOT, src, dst, '0);
        result_dst.push_back(dst);
    endtask

    function automatic simd_pkg::addr_t pick_src();
        return loaded_src[next_bits(8) % loaded_src.size()];
    endfunction

    task automatic read_back_all();
        foreach (result_dst[i]) begin
            issue_instr(`SIMD_OP_READ, result_dst[i], '0, '0);
        end
        idle_cycles(1);
    endtask

    initial begin
        #(NUM_INSTR * 8 * CLK_PERIOD + 200);
        $display("timeout: the test sequence did not finish in time");
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        simd_pkg::addr_t   src;
        simd_pkg::addr_t   dst;
        simd_pkg::vec_t    data;
        simd_pkg::opcode_t op;

        reset_ff      = 1'b1;
        i_valid       = 1'b0;
        i_instruction = '0;
        i_data        = '0;
        lfsr_state    = 32'h5569;
        weight_model  = '0;
        exp_done      = 1'b0;
        exp_read      = 1'b0;
        exp_rdata     = '0;
        cycle_count   = 0;
        checks        = 0;
        errors        = 0;

        repeat (5) begin
            @(posedge clk);
            #1;
            compare_value("o_done", o_done, 1'b0);
            compare_value("o_dot_done", o_dot_done, 1'b0);
            compare_value("o_pipe_status", o_pipe_status, 4'b0);
        end
        reset_ff = 1'b0;
        idle_cycles(2);

        // random vector and weight loads
        for (int i = 0; i < NUM_LOADS; i++) begin
            dst  = random_addr();
            data = random_vector();
            if (next_bits(2) == 2'd0) begin
                issue_instr(`SIMD_OP_LOAD_WEIGHT, '0, dst, data);
            end else begin
                issue_instr(`SIMD_OP_LOAD_INPUT, '0, dst, data);
                loaded_src.push_back(dst);
            end
        end
        if (loaded_src.size() == 0) begin
            issue_instr(`SIMD_OP_LOAD_INPUT, '0, 8'h00, random_vector());
            loaded_src.push_back(8'h00);
        end
        issue_instr(`SIMD_OP_LOAD_WEIGHT, '0, '0, random_vector());
        idle_cycles(2);

        // isolated dot product then its read
        issue_dot(pick_src(), random_addr());
        idle_cycles(6);
        issue_instr(`SIMD_OP_READ, result_dst[0], '0, '0);
        idle_cycles(2);

        // back-to-back issue
        for (int i = 0; i < NUM_BURST; i++) begin
            issue_dot(pick_src(), random_addr());
        end
        idle_cycles(6);
        read_back_all();

        // weight change between two dots on the same vector
        src = pick_src();
        dst = random_addr();
        issue_dot(src, dst);
        issue_instr(`SIMD_OP_LOAD_WEIGHT, '0, '0, random_vector());
        issue_dot(src, dst + 8'd1);
        idle_cycles(6);
        read_back_all();

        // ignored opcodes and unqualified instructions
        for (int i = 0; i < NUM_IGNORED; i++) begin
            if (i % 2 == 0) begin
                case ((i / 2) % 4)
                    0:       op = 3'd0;
                    1:       op = 3'd2;
                    2:       op = 3'd6;
                    default: op = 3'd7;
                endcase
                run_cycle(1'b1, make_inst(op, random_addr(), random_addr()),
                          random_vector());
            end else begin
                case ((i / 2) % 4)
                    0:       op = `SIMD_OP_DOT;
                    1:       op = `SIMD_OP_LOAD_INPUT;
                    2:       op = `SIMD_OP_LOAD_WEIGHT;
                    default: op = `SIMD_OP_READ;
                endcase
                run_cycle(1'b0, make_inst(op, random_addr(), random_addr()),
                          random_vector());
            end
        end
        idle_cycles(6);
        read_back_all();
        idle_cycles(4);

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* src.f */
+incdir+hdl
hdl/simd_pkg.sv
hdl/simd_sram.sv
hdl/inst_decoder.sv
hdl/dot_pipe.sv
hdl/simd_top.sv
verif/tb_clock.sv
verif/simd_tb.sv

/* Bender.yml */
package:
  name: simd_dot

export_include_dirs:
  - hdl

sources:
  - hdl/simd_pkg.sv
  - hdl/simd_sram.sv
  - hdl/inst_decoder.sv
  - hdl/dot_pipe.sv
  - hdl/simd_top.sv
  - target: simulation
    files:
      - verif/tb_clock.sv
      - verif/simd_tb.sv
